// File: bcm_scan_sequencer.sv
`timescale 1ns/1ps
`include "hub75_settings.svh"

module bcm_scan_sequencer
  import hub75_pixel_pkg::*;
  import hub75_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      run,
  input  logic      waiting,
  output logic      shift_start,
  output logic      show,
  output row_addr_t row_addr,
  output row_addr_t fetch_row,
  output plane_t    plane,
  output logic      frame_done
);

  localparam row_addr_t LAST_ROW = row_addr_t'(`PANEL_HALF_ROWS - 1);
  localparam plane_t LAST_PLANE = plane_t'(`COLOR_BITS - 1);

  seq_state_t  state;
  disp_count_t disp_cnt;
  logic        last_plane;
  logic        frame_end;
  logic        end_latched;

  assign last_plane  = (plane == LAST_PLANE);
  assign frame_end   = last_plane && (fetch_row == LAST_ROW);
  assign shift_start = (state == SEQ_START);

  // Show once the current plane has had its full slot and the next one is ready.
  assign show = (state == SEQ_WAIT) && waiting && (disp_cnt == '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= SEQ_IDLE;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (run) begin
            state <= SEQ_START;
          end
        end
        SEQ_START: state <= SEQ_WAIT;
        SEQ_WAIT: begin
          if (show) begin
            state <= (frame_end && !run) ? SEQ_IDLE : SEQ_START;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // Shift pointer advances at show, the display row takes the one just shifted.
  always_ff @(posedge clk) begin
    if (rst) begin
      fetch_row <= '0;
      plane     <= '0;
      row_addr  <= '0;
    end else if (show) begin
      row_addr <= fetch_row;
      if (last_plane) begin
        plane     <= '0;
        fetch_row <= (fetch_row == LAST_ROW) ? '0 : fetch_row + row_addr_t'(1);
      end else begin
        plane <= plane + plane_t'(1);
      end
    end
  end

  // Binary weighted display time of the plane being shown.
  always_ff @(posedge clk) begin
    if (rst) begin
      disp_cnt <= '0;
    end else if (show) begin
      disp_cnt <= disp_count_t'(`DISPLAY_BASE) << plane;
    end else if (disp_cnt != '0) begin
      disp_cnt <= disp_cnt - disp_count_t'(1);
    end
  end

  // end_latched lines up with the latch, frame_done follows it
  always_ff @(posedge clk) begin
    if (rst) begin
      end_latched <= 1'b0;
      frame_done  <= 1'b0;
    end else begin
      end_latched <= show && frame_end;
      frame_done  <= end_latched;
    end
  end

endmodule

// File: frame_memory.sv
`timescale 1ns/1ps

module frame_memory
  import hub75_pixel_pkg::*;
(
  input  logic      clk,
  input  logic      wr_en,
  input  mem_addr_t wr_addr,
  input  pixel_t    wr_upper,
  input  pixel_t    wr_lower,
  input  mem_addr_t rd_addr,
  output pixel_t    rd_upper,
  output pixel_t    rd_lower
);

  // Upper and lower halves share an address, one entry per column of a half-row.
  pixel_t upper_mem [MEM_DEPTH];
  pixel_t lower_mem [MEM_DEPTH];

  // Host write port.
  always_ff @(posedge clk) begin
    if (wr_en) begin
      upper_mem[wr_addr] <= wr_upper;
      lower_mem[wr_addr] <= wr_lower;
    end
  end

  // Registered read for the shifter.
  // A read of the address being written sees the old pair.
  always_ff @(posedge clk) begin
    rd_upper <= upper_mem[rd_addr];
    rd_lower <= lower_mem[rd_addr];
  end

endmodule

// File: hub75_ctrl_pkg.sv
`include "hub75_settings.svh"

package hub75_ctrl_pkg;

  localparam int PLANE_BITS = ($clog2(`COLOR_BITS) > 0) ? $clog2(`COLOR_BITS) : 1;

  // Longest display slot, that of the most significant plane.
  localparam int DISP_MAX = `DISPLAY_BASE << (`COLOR_BITS - 1);
  localparam int DISP_BITS = $clog2(DISP_MAX + 1);

  typedef enum logic [2:0] {
    IDLE,
    START_SHIFT,
    SHIFTING,
    WAIT_ORDER,
    LATCH,
    SHOW
  } row_drv_state_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_START,
    SEQ_WAIT
  } seq_state_t;

  typedef logic [PLANE_BITS-1:0] plane_t;
  typedef logic [DISP_BITS-1:0] disp_count_t;

endpackage

// File: hub75_input.txt
# name dim fill value disp0 disp1 disp2 (disp is oe_n low cycles per bit plane)
# fill r draws both halves at random, fill c writes value above and its complement below
random_a 0 r 000 40 80 160
full_white 0 c 1ff 40 80 160
dim_random 1 r 000 0 0 0
random_b 0 r 000 40 80 160
pattern_0a5 0 c 0a5 40 80 160

// File: hub75_panel_top.sv
`timescale 1ns/1ps

module hub75_panel_top
  import hub75_pixel_pkg::*;
  import hub75_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      run,
  input  logic      dim,
  input  logic      wr_en,
  input  mem_addr_t wr_addr,
  input  pixel_t    wr_upper,
  input  pixel_t    wr_lower,
  output logic      frame_done,
  output rgb_lane_t rgb0,
  output rgb_lane_t rgb1,
  output logic      sclk,
  output row_addr_t abcde,
  output logic      latch,
  output logic      oe_n
);

  mem_addr_t rd_addr;
  pixel_t    rd_upper;
  pixel_t    rd_lower;
  col_addr_t col_index;
  logic      shift_start;
  logic      show;
  logic      waiting;
  row_addr_t row_addr;
  row_addr_t fetch_row;
  plane_t    plane;

  // Half-row being shifted selects the memory row.
  assign rd_addr = {fetch_row[HALF_ROW_BITS-1:0], col_index};

  frame_memory mem0 (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_upper(wr_upper),
    .wr_lower(wr_lower),
    .rd_addr (rd_addr),
    .rd_upper(rd_upper),
    .rd_lower(rd_lower)
  );

  bcm_scan_sequencer seq0 (
    .clk        (clk),
    .rst        (rst),
    .run        (run),
    .waiting    (waiting),
    .shift_start(shift_start),
    .show       (show),
    .row_addr   (row_addr),
    .fetch_row  (fetch_row),
    .plane      (plane),
    .frame_done (frame_done)
  );

  hub75_row_driver drv0 (
    .clk        (clk),
    .rst        (rst),
    .shift_start(shift_start),
    .show       (show),
    .dim        (dim),
    .row_addr   (row_addr),
    .plane      (plane),
    .rd_upper   (rd_upper),
    .rd_lower   (rd_lower),
    .col_index  (col_index),
    .waiting    (waiting),
    .rgb0       (rgb0),
    .rgb1       (rgb1),
    .sclk       (sclk),
    .abcde      (abcde),
    .latch      (latch),
    .oe_n       (oe_n)
  );

endmodule

// File: hub75_pixel_pkg.sv
`include "hub75_settings.svh"

package hub75_pixel_pkg;

  localparam int COL_BITS = $clog2(`PANEL_COLS);
  localparam int HALF_ROW_BITS = $clog2(`PANEL_HALF_ROWS);
  localparam int MEM_DEPTH = `PANEL_HALF_ROWS * `PANEL_COLS;

  // One channel intensity.
  typedef logic [`COLOR_BITS-1:0] color_t;

  typedef struct packed {
    color_t r;
    color_t g;
    color_t b;
  } pixel_t;

  // One bit per channel, as on a panel data lane.
  typedef struct packed {
    logic r;
    logic g;
    logic b;
  } rgb_lane_t;

  typedef logic [COL_BITS-1:0] col_addr_t;
  typedef logic [`ROW_ADDR_BITS-1:0] row_addr_t;

  // Half-row in the upper bits, column in the lower bits.
  typedef logic [HALF_ROW_BITS+COL_BITS-1:0] mem_addr_t;

endpackage

// File: hub75_props.sv
`timescale 1ns/1ps

module hub75_props
  import hub75_ctrl_pkg::*;
(
  input logic           clk,
  input logic           rst,
  input logic           latch,
  input logic           oe_n,
  input logic           show,
  input logic           waiting,
  input logic           sclk,
  input row_drv_state_t state
);

  // Latch is a single-cycle strobe.
  latch_pulse: assert property (@(posedge clk) disable iff (rst) latch |=> !latch)
    else $error("latch stayed high for more than one cycle");

  // LEDs are dark while the row latch updates.
  dark_latch: assert property (@(posedge clk) disable iff (rst) latch |-> oe_n)
    else $error("oe_n low during a latch cycle");

  show_waiting: assert property (@(posedge clk) disable iff (rst) show |-> waiting)
    else $error("show arrived while the driver was not waiting");

  // The panel clock only moves while columns are being shifted.
  sclk_shifting: assert property (@(posedge clk) disable iff (rst)
    !$stable(sclk) |-> ($past(state) == SHIFTING))
    else $error("sclk changed outside the SHIFTING state");

endmodule

// File: hub75_row_driver.sv
`timescale 1ns/1ps

module hub75_row_driver
  import hub75_pixel_pkg::*;
  import hub75_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      shift_start,
  input  logic      show,
  input  logic      dim,
  input  row_addr_t row_addr,
  input  plane_t    plane,
  input  pixel_t    rd_upper,
  input  pixel_t    rd_lower,
  output col_addr_t col_index,
  output logic      waiting,
  output rgb_lane_t rgb0,
  output rgb_lane_t rgb1,
  output logic      sclk,
  output row_addr_t abcde,
  output logic      latch,
  output logic      oe_n
);

  row_drv_state_t state;
  row_drv_state_t state_next;
  logic           latched_once;
  logic           shift_init;
  logic           shift_clear;
  logic           shift_done;
  logic           lit_n;

  always_ff @(posedge clk) begin
    if (rst) begin
      state        <= IDLE;
      latched_once <= 1'b0;
    end else begin
      state <= state_next;
      if (state == IDLE) begin
        latched_once <= 1'b0;
      end else if (state == LATCH) begin
        latched_once <= 1'b1;
      end
    end
  end

  // A shift start may already come in the latch cycle.
  always_comb begin
    state_next = state;
    case (state)
      IDLE:        if (shift_start) state_next = START_SHIFT;
      START_SHIFT: state_next = SHIFTING;
      SHIFTING:    if (shift_done) state_next = WAIT_ORDER;
      WAIT_ORDER:  if (show) state_next = LATCH;
      LATCH:       state_next = shift_start ? START_SHIFT : SHOW;
      SHOW:        if (shift_start) state_next = START_SHIFT;
      default:     state_next = IDLE;
    endcase
  end

  // LEDs stay dark until a valid row has been latched.
  assign lit_n = ~latched_once | dim;

  always_comb begin
    shift_init  = 1'b0;
    shift_clear = 1'b1;
    latch       = 1'b0;
    oe_n        = 1'b1;
    waiting     = 1'b0;
    case (state)
      START_SHIFT: begin
        shift_init  = 1'b1;
        shift_clear = 1'b0;
        oe_n        = lit_n;
      end
      SHIFTING: begin
        shift_clear = 1'b0;
        oe_n        = lit_n;
      end
      WAIT_ORDER: begin
        waiting = 1'b1;
        oe_n    = lit_n;
      end
      LATCH: begin
        latch = 1'b1;
      end
      SHOW: begin
        oe_n = lit_n;
      end
      default: begin
        oe_n = 1'b1;
      end
    endcase
  end

  // Row address follows the sequencer, which updates it with the latch.
  assign abcde = row_addr;

  rgb_column_shifter shifter0 (
    .clk        (clk),
    .rst        (rst),
    .shift_clear(shift_clear),
    .shift_init (shift_init),
    .plane      (plane),
    .rd_upper   (rd_upper),
    .rd_lower   (rd_lower),
    .col_index  (col_index),
    .lane_upper (rgb0),
    .lane_lower (rgb1),
    .sclk       (sclk),
    .shift_done (shift_done)
  );

endmodule

// File: hub75_settings.svh
`ifndef HUB75_SETTINGS_SVH
`define HUB75_SETTINGS_SVH

// Panel geometry, one HUB75 panel of two halves.
`define PANEL_COLS 16
`define PANEL_HALF_ROWS 8
`define ROW_ADDR_BITS 5

// Bits per colour channel, also the number of BCM bit planes.
`define COLOR_BITS 3

// Display cycles of plane 0; must cover 2*PANEL_COLS+4 for the next shift.
`define DISPLAY_BASE 40

`endif

// File: hub75_tb.sv
`timescale 1ns/1ps
`include "hub75_settings.svh"

module hub75_tb
  import hub75_pixel_pkg::*;
  import hub75_ctrl_pkg::*;
();

  localparam int FRAME_LATCHES = `PANEL_HALF_ROWS * `COLOR_BITS;

  logic      clk, rst, run, dim, wr_en;
  mem_addr_t wr_addr;
  pixel_t    wr_upper, wr_lower;
  logic      frame_done, sclk, latch, oe_n;
  rgb_lane_t rgb0, rgb1;
  row_addr_t abcde;

  // Expected display counts of the test list are stored flat with COLOR_BITS entries per test.
  reg [8*24-1:0] t_name[$];
  reg [7:0]      t_mode[$];
  logic          t_dim[$];
  pixel_t        t_value[$];
  disp_count_t   t_exp[$];

  pixel_t        model_up[];
  pixel_t        model_lo[];
  rgb_lane_t     lanes_up[$];
  rgb_lane_t     lanes_lo[$];
  reg [8*24-1:0] cur_name;
  int            cur;
  int            seed = 32'h52844428;
  int            errors = 0;
  int            checks = 0;
  int            cycles = 0;
  int            cycle_limit = 0;
  int            low_cnt, frame_latches, frame_dones, prev_plane;
  bit            seen_latch, early_lit;

  hub75_panel_top dut0 (
    .clk(clk), .rst(rst), .run(run), .dim(dim),
    .wr_en(wr_en), .wr_addr(wr_addr), .wr_upper(wr_upper), .wr_lower(wr_lower),
    .frame_done(frame_done), .rgb0(rgb0), .rgb1(rgb1), .sclk(sclk),
    .abcde(abcde), .latch(latch), .oe_n(oe_n)
  );

  bind hub75_row_driver hub75_props props0 (
    .clk(clk), .rst(rst), .latch(latch), .oe_n(oe_n), .show(show),
    .waiting(waiting), .sclk(sclk), .state(state)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("timeout: no end of frame within %0d cycles", cycle_limit);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Bit p of each channel as the panel should see it for plane p.
  function automatic rgb_lane_t plane_lane(pixel_t px, int p);
    rgb_lane_t lane;
    color_t    mask;
    mask   = color_t'(1) << p;
    lane.r = |(px.r & mask);
    lane.g = |(px.g & mask);
    lane.b = |(px.b & mask);
    return lane;
  endfunction

  task automatic check_lane(input string what, input rgb_lane_t exp, input rgb_lane_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %0s: %0s expected %b actual %b", cur_name, what, exp, act);
    end
  endtask

  task automatic check_row(input string what, input row_addr_t exp, input row_addr_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %0s: %0s expected %0d actual %0d", cur_name, what, exp, act);
    end
  endtask

  task automatic check_count(input string what, input disp_count_t exp, input disp_count_t act);
    checks++;
    if (exp !== act) begin
      errors++;
      $display("error %0s: %0s expected %0d actual %0d", cur_name, what, exp, act);
    end
  endtask

  // Writes the whole frame memory and keeps the same image in the model.
  task automatic load_image(input int t);
    pixel_t up;
    pixel_t lo;
    for (int a = 0; a < MEM_DEPTH; a++) begin
      if (t_mode[t] == "r") begin
        up = pixel_t'($random(seed));
        lo = pixel_t'($random(seed));
      end else begin
        up = t_value[t];
        lo = ~t_value[t];
      end
      model_up[a] = up;
      model_lo[a] = lo;
      wr_en       = 1'b1;
      wr_addr     = mem_addr_t'(a);
      wr_upper    = up;
      wr_lower    = lo;
      @(negedge clk);
    end
    wr_en = 1'b0;
  endtask

  // The panel pins are sampled mid-cycle where all DUT outputs are settled.
  always @(negedge clk) begin
    int row;
    int pl;
    if (!rst) begin
      if (sclk) begin
        lanes_up.push_back(rgb0);
        lanes_lo.push_back(rgb1);
      end
      if (!oe_n) low_cnt++;
      if (!seen_latch && !oe_n && !early_lit) begin
        early_lit = 1'b1;
        errors++;
        $display("oe_n went low before the first row was latched");
      end
      if (latch) begin
        seen_latch = 1'b1;
        row = frame_latches / `COLOR_BITS;
        pl  = frame_latches % `COLOR_BITS;
        if (frame_latches >= FRAME_LATCHES) begin
          errors++;
          $display("%0s: more than %0d latches in one frame", cur_name, FRAME_LATCHES);
        end else begin
          check_row("abcde at latch", row_addr_t'(row), abcde);
          if (lanes_up.size() != `PANEL_COLS) begin
            errors++;
            $display("%0s: %0d columns shifted before latch %0d instead of %0d",
                     cur_name, lanes_up.size(), frame_latches, `PANEL_COLS);
          end else begin
            for (int c = 0; c < `PANEL_COLS; c++) begin
              check_lane($sformatf("rgb0 row %0d plane %0d col %0d", row, pl, c),
                         plane_lane(model_up[row * `PANEL_COLS + c], pl), lanes_up[c]);
              check_lane($sformatf("rgb1 row %0d plane %0d col %0d", row, pl, c),
                         plane_lane(model_lo[row * `PANEL_COLS + c], pl), lanes_lo[c]);
            end
          end
          // Low run since the previous latch belongs to the previous plane.
          if (frame_latches > 0) begin
            check_count($sformatf("oe_n low cycles of plane %0d", prev_plane),
                        t_exp[cur * `COLOR_BITS + prev_plane], disp_count_t'(low_cnt));
          end
        end
        prev_plane = pl;
        low_cnt    = 0;
        frame_latches++;
        lanes_up.delete();
        lanes_lo.delete();
      end
      if (frame_done) frame_dones++;
    end
  end

  initial begin
    int            fd;
    int            dim_i;
    int            val_i;
    int            e0, e1, e2;
    int            errs_before;
    reg [8*96-1:0] line;
    reg [8*24-1:0] name;
    reg [7:0]      mode;
    rst      = 1'b1;
    run      = 1'b0;
    dim      = 1'b0;
    wr_en    = 1'b0;
    wr_addr  = '0;
    wr_upper = '0;
    wr_lower = '0;
    model_up = new[MEM_DEPTH];
    model_lo = new[MEM_DEPTH];
    fd = $fopen("hub75_input.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("could not open hub75_input.txt");
    end else begin
      // Comment lines fail the numeric fields and are skipped.
      while ($fgets(line, fd) != 0) begin
        if ($sscanf(line, "%s %d %s %h %d %d %d", name, dim_i, mode, val_i, e0, e1, e2) == 7) begin
          t_name.push_back(name);
          t_dim.push_back(dim_i != 0);
          t_mode.push_back(mode);
          t_value.push_back(pixel_t'(val_i));
          t_exp.push_back(disp_count_t'(e0));
          t_exp.push_back(disp_count_t'(e1));
          t_exp.push_back(disp_count_t'(e2));
        end
      end
      $fclose(fd);
    end
    if (t_name.size() == 0) begin
      errors++;
      $display("no tests found in hub75_input.txt");
    end
    cycle_limit = t_name.size() * `PANEL_HALF_ROWS * (`DISPLAY_BASE << `COLOR_BITS) * 2;
    repeat (2) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);
    if (latch !== 1'b0 || sclk !== 1'b0 || oe_n !== 1'b1) begin
      errors++;
      $display("panel pins not idle after reset");
    end
    for (int t = 0; t < t_name.size(); t++) begin
      cur         = t;
      cur_name    = t_name[t];
      dim         = t_dim[t];
      errs_before = errors;
      load_image(t);
      frame_latches = 0;
      frame_dones   = 0;
      // One cycle of run starts exactly one frame.
      run = 1'b1;
      @(negedge clk);
      run = 1'b0;
      while (!frame_done) @(negedge clk);
      repeat (3) @(posedge clk);
      check_count("latches per frame", disp_count_t'(FRAME_LATCHES), disp_count_t'(frame_latches));
      check_count("frame_done pulses", disp_count_t'(1), disp_count_t'(frame_dones));
      $display("test %0s: %0d errors", cur_name, errors - errs_before);
      @(negedge clk);
    end
    $display("%0d tests, %0d checks, %0d errors", t_name.size(), checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

// File: list.f
+incdir+.
hub75_pixel_pkg.sv
hub75_ctrl_pkg.sv
frame_memory.sv
rgb_column_shifter.sv
hub75_row_driver.sv
bcm_scan_sequencer.sv
hub75_panel_top.sv
hub75_props.sv
hub75_tb.sv

// File: rgb_column_shifter.sv
`timescale 1ns/1ps
`include "hub75_settings.svh"

module rgb_column_shifter
  import hub75_pixel_pkg::*;
  import hub75_ctrl_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      shift_clear,
  input  logic      shift_init,
  input  plane_t    plane,
  input  pixel_t    rd_upper,
  input  pixel_t    rd_lower,
  output col_addr_t col_index,
  output rgb_lane_t lane_upper,
  output rgb_lane_t lane_lower,
  output logic      sclk,
  output logic      shift_done
);

  localparam col_addr_t LAST_COL = col_addr_t'(`PANEL_COLS - 1);

  logic      active;
  logic      phase;
  logic      last_col;
  logic      sclk_q;
  logic      done_q;
  col_addr_t col_q;

  // Picks one bit plane out of a pixel.
  function automatic rgb_lane_t plane_bits(pixel_t px, plane_t p);
    rgb_lane_t lane;
    lane.r = px.r[p];
    lane.g = px.g[p];
    lane.b = px.b[p];
    return lane;
  endfunction

  // Phase 0 fetches or holds low, phase 1 has the data up and raises sclk next.
  // The column moves on together with the rising sclk, the RAM still holds the old word.
  always_ff @(posedge clk) begin
    if (rst || shift_clear) begin
      active   <= 1'b0;
      phase    <= 1'b0;
      last_col <= 1'b0;
      sclk_q   <= 1'b0;
      done_q   <= 1'b0;
      col_q    <= '0;
    end else if (shift_init) begin
      active   <= 1'b1;
      phase    <= 1'b0;
      last_col <= 1'b0;
      sclk_q   <= 1'b0;
      done_q   <= 1'b0;
      col_q    <= '0;
    end else begin
      done_q <= 1'b0;
      if (active) begin
        phase <= ~phase;
        if (phase) begin
          sclk_q   <= 1'b1;
          col_q    <= col_q + col_addr_t'(1);
          last_col <= (col_q == LAST_COL);
        end else begin
          sclk_q <= 1'b0;
          // high phase of the last column just ended
          if (last_col) begin
            active <= 1'b0;
            done_q <= 1'b1;
          end
        end
      end
    end
  end

  assign col_index  = col_q;
  assign lane_upper = plane_bits(rd_upper, plane);
  assign lane_lower = plane_bits(rd_lower, plane);
  assign sclk       = sclk_q;
  assign shift_done = done_q;

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run with Verilator, then look for the fail message in the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module hub75_tb -f list.f -o hub75_sim \
  && ./obj_dir/hub75_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
